// ==== bench/xreg_testdata.txt ====
// op (1 write, 2 read)  address  write data  expected read data, all hex
// entry e partition p sits at 0x80 + 8*e + 4*p, the control register at 0x00
2 98 00000000 00000000
2 9C 00000000 00000000
1 84 0000000A 00000000
1 80 12345678 00000000
2 80 00000000 12345678
2 84 00000000 0000000A
1 00 A5A50000 00000000
2 00 00000000 A5A50000
2 04 00000000 00000000
1 00 00000001 00000000
1 84 00000005 00000000
1 80 DEADBEEF 00000000
2 80 00000000 12345678
2 84 00000000 0000000A
1 00 00000000 00000000
1 FC FFFFFFF3 00000000
1 F8 CAFEF00D 00000000
1 84 00000006 00000000
1 80 0BADF00D 00000000
2 F8 00000000 CAFEF00D
2 FC 00000000 00000003
2 80 00000000 0BADF00D
2 84 00000000 00000006
2 98 00000000 00000000
2 9C 00000000 00000000
2 00 00000000 00000000

// ==== build.f ====
+incdir+include
hdl/xreg_pkg.sv
hdl/onehot_mux.sv
hdl/reg_bus_frontend.sv
hdl/snapshot_reg_mem.sv
hdl/entry_mem.sv
hdl/resp_path.sv
hdl/xreg_top.sv
bench/tb_clock.sv
bench/xreg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the xreg testbench with Verilator

LOG=sim.log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

verilator --binary --timing -Wno-fatal --top-module xreg_tb -f build.f -o xreg_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/xreg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

// ==== bench/xreg_tb.sv ====
module xreg_tb
   import xreg_pkg::*;
();

   localparam int OP_WRITE      = 1;
   localparam int OP_READ       = 2;
   localparam int MAX_OPS       = 64;
   localparam int CYCLES_PER_OP = 50;
   localparam int RESET_CYCLES  = 4;

   logic                   clk;
   logic                   rst_n;
   logic                   host_wr;
   logic                   host_rd;
   logic [HOST_ADDR_W-1:0] host_addr;
   logic [DATA_W-1:0]      host_wdata;
   logic                   host_ack;
   logic [DATA_W-1:0]      host_rdata;

   // four words per operation: op, address, write data, expected read data
   logic [DATA_W-1:0] testdata [4*MAX_OPS];
   int                op_count     = 0;
   int                strobe_count = 0;
   int                ack_count    = 0;
   logic              data_loaded  = 1'b0;

   tb_clock #(
      .PERIOD       (40),
      .RESET_CYCLES (RESET_CYCLES)
   ) clock_inst (
      .clk   (clk),
      .rst_n (rst_n)
   );

   xreg_top xreg_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .host_wr    (host_wr),
      .host_rd    (host_rd),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_ack   (host_ack),
      .host_rdata (host_rdata)
   );

   always @(posedge clk) begin
      if (rst_n && host_ack) begin
         ack_count <= ack_count + 1;
      end
   end

   task automatic report_mismatch(input string msg);
      $display("FAIL at time %0t: %s", $time, msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_rdata(input logic [HOST_ADDR_W-1:0] addr, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp, input int line);
      if (got !== exp) begin
         report_mismatch($sformatf("line %0d read of 0x%02h returned 0x%08h, expected 0x%08h",
                                   line, addr, got, exp));
      end
   endtask

   task automatic check_ack_count(input int strobes, input int acks);
      if (acks != strobes) begin
         report_mismatch($sformatf("%0d strobes issued but %0d acks seen", strobes, acks));
      end
   endtask

   task automatic load_testdata();
      for (int k = 0; k < 4*MAX_OPS; k++) begin
         testdata[k] = '0;
      end
      $readmemh("bench/xreg_testdata.txt", testdata);
      // op code 0 marks the end of the file
      while (op_count < MAX_OPS && testdata[4*op_count] != '0) begin
         op_count++;
      end
      if (op_count == 0) begin
         $display("no operations could be read from bench/xreg_testdata.txt");
         $display("FAIL: see errors above");
         $fatal(1, "empty test data");
      end
      data_loaded = 1'b1;
   endtask

   task automatic run_op(input int n);
      logic [DATA_W-1:0]      op;
      logic [HOST_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
      logic [DATA_W-1:0]      exp;
      op    = testdata[4*n];
      addr  = testdata[4*n+1][HOST_ADDR_W-1:0];
      wdata = testdata[4*n+2];
      exp   = testdata[4*n+3];
      if (op != DATA_W'(OP_WRITE) && op != DATA_W'(OP_READ)) begin
         report_mismatch($sformatf("line %0d has unknown op code %0h", n + 1, op));
      end
      @(posedge clk);
      host_wr    <= (op == DATA_W'(OP_WRITE));
      host_rd    <= (op == DATA_W'(OP_READ));
      host_addr  <= addr;
      host_wdata <= wdata;
      strobe_count++;
      @(posedge clk);
      host_wr <= 1'b0;
      host_rd <= 1'b0;
      // host_rdata is valid in the ack cycle
      do begin
         @(posedge clk);
      end while (host_ack !== 1'b1);
      if (op == DATA_W'(OP_READ)) begin
         check_rdata(addr, host_rdata, exp, n + 1);
      end
   endtask

   initial begin
      host_wr    = 1'b0;
      host_rd    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      load_testdata();
      wait (rst_n === 1'b1);
      for (int n = 0; n < op_count; n++) begin
         // uneven idle gaps move requests onto refresh stalls of the memory
         repeat (n % 3) @(posedge clk);
         run_op(n);
      end
      // a few idle cycles so a stray extra ack would be counted
      repeat (4) @(posedge clk);
      check_ack_count(strobe_count, ack_count);
      $display("PASS: all tests");
      $finish;
   end

   initial begin
      int limit;
      wait (data_loaded === 1'b1);
      limit = op_count * CYCLES_PER_OP + RESET_CYCLES + 10;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d cycles, the DUT stopped acknowledging strobes",
               limit);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
   end

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset released on a rising edge after RESET_CYCLES cycles
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// ==== hdl/xreg_top.sv ====
module xreg_top
   import xreg_pkg::*;
#(
   parameter int REFRESH_PERIOD = 7
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   host_wr,
   input  logic                   host_rd,
   input  logic [HOST_ADDR_W-1:0] host_addr,
   input  logic [DATA_W-1:0]      host_wdata,
   output logic                   host_ack,
   output logic [DATA_W-1:0]      host_rdata
);

   logic                   req_vld;
   logic                   req_rdy;
   logic [HOST_ADDR_W-1:0] addr;
   logic                   wr_en;
   logic                   rd_en;
   logic [DATA_W-1:0]      wr_data;
   logic                   ctrl_wr;
   logic                   ctrl_rd;
   logic [DATA_W-1:0]      ctrl_wdata;
   logic                   ack_vld;
   logic [DATA_W-1:0]      rd_data;
   logic                   write_protect;
   logic                   entry_vld;
   logic [ENTRY_W-1:0]     mem_addr;
   logic                   mem_req_vld;
   logic                   mem_req_rdy;
   logic                   mem_rd_en;
   logic                   mem_wr_en;
   logic [MEM_W-1:0]       mem_wr_data;
   logic                   mem_ack_vld;
   logic [MEM_W-1:0]       mem_rd_data;

   reg_bus_frontend frontend_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .host_wr    (host_wr),
      .host_rd    (host_rd),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .req_vld    (req_vld),
      .addr       (addr),
      .wr_en      (wr_en),
      .rd_en      (rd_en),
      .wr_data    (wr_data),
      .ctrl_wr    (ctrl_wr),
      .ctrl_rd    (ctrl_rd),
      .wdata      (ctrl_wdata),
      .req_rdy    (req_rdy)
   );

   snapshot_reg_mem #(
      .DATA_WIDTH  (DATA_W),
      .MEM_WIDTH   (MEM_W),
      .ENTRY_WIDTH (ENTRY_W),
      .BASE        (WIN_BASE)
   ) bridge_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .addr          (addr),
      .wr_en         (wr_en),
      .rd_en         (rd_en),
      .wr_data       (wr_data),
      .req_vld       (req_vld),
      .req_rdy       (req_rdy),
      .ack_vld       (ack_vld),
      .rd_data       (rd_data),
      .write_protect (write_protect),
      .entry_vld     (entry_vld),
      .mem_addr      (mem_addr),
      .mem_req_vld   (mem_req_vld),
      .mem_rd_en     (mem_rd_en),
      .mem_wr_en     (mem_wr_en),
      .mem_wr_data   (mem_wr_data),
      .mem_req_rdy   (mem_req_rdy),
      .mem_ack_vld   (mem_ack_vld),
      .mem_rd_data   (mem_rd_data)
   );

   entry_mem #(
      .MEM_WIDTH      (MEM_W),
      .ENTRY_WIDTH    (ENTRY_W),
      .REFRESH_PERIOD (REFRESH_PERIOD)
   ) mem_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .mem_req_vld (mem_req_vld),
      .mem_addr    (mem_addr),
      .mem_rd_en   (mem_rd_en),
      .mem_wr_en   (mem_wr_en),
      .mem_wr_data (mem_wr_data),
      .mem_req_rdy (mem_req_rdy),
      .mem_ack_vld (mem_ack_vld),
      .mem_rd_data (mem_rd_data),
      .entry_vld   (entry_vld)
   );

   resp_path #(
      .DATA_WIDTH (DATA_W)
   ) resp_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .ctrl_wr       (ctrl_wr),
      .ctrl_rd       (ctrl_rd),
      .wdata         (ctrl_wdata),
      .ack_vld       (ack_vld),
      .rd_data       (rd_data),
      .write_protect (write_protect),
      .host_ack      (host_ack),
      .host_rdata    (host_rdata)
   );

endmodule

// ==== hdl/resp_path.sv ====
module resp_path #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  ctrl_wr,
   input  logic                  ctrl_rd,
   input  logic [DATA_WIDTH-1:0] wdata,
   input  logic                  ack_vld,
   input  logic [DATA_WIDTH-1:0] rd_data,
   output logic                  write_protect,
   output logic                  host_ack,
   output logic [DATA_WIDTH-1:0] host_rdata
);

   logic [DATA_WIDTH-1:0]   ctrl_reg;
   logic [2*DATA_WIDTH-1:0] resp_src;
   logic [1:0]              resp_sel;
   logic [DATA_WIDTH-1:0]   resp_word;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_reg <= '0;
      end else if (ctrl_wr) begin
         ctrl_reg <= wdata;
      end
   end

   assign write_protect = ctrl_reg[0];

   // wdata masks the register on control reads, zero when nothing decoded
   assign resp_src = {rd_data, ctrl_reg & wdata};
   assign resp_sel = {ack_vld, ctrl_rd};

   onehot_mux #(
      .WIDTH (DATA_WIDTH),
      .CNT   (2)
   ) resp_mux_inst (
      .din  (resp_src),
      .sel  (resp_sel),
      .dout (resp_word)
   );

   // a control write acks with zero data
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         host_ack <= 1'b0;
      end else begin
         host_ack <= ctrl_wr | ctrl_rd | ack_vld;
      end
   end

   always_ff @(posedge clk) begin
      host_rdata <= resp_word;
   end

endmodule

// ==== hdl/entry_mem.sv ====
module entry_mem #(
   parameter int MEM_WIDTH      = 36,
   parameter int ENTRY_WIDTH    = 4,
   parameter int REFRESH_PERIOD = 7
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   mem_req_vld,
   input  logic [ENTRY_WIDTH-1:0] mem_addr,
   input  logic                   mem_rd_en,
   input  logic                   mem_wr_en,
   input  logic [MEM_WIDTH-1:0]   mem_wr_data,
   output logic                   mem_req_rdy,
   output logic                   mem_ack_vld,
   output logic [MEM_WIDTH-1:0]   mem_rd_data,
   output logic                   entry_vld
);

   localparam int DEPTH = 1 << ENTRY_WIDTH;
   localparam int CNT_W = $clog2(REFRESH_PERIOD);

   logic [MEM_WIDTH-1:0] mem [DEPTH];
   logic [DEPTH-1:0]     valid;
   logic [CNT_W-1:0]     refresh_cnt;
   logic                 take;

   // one busy cycle at the end of every refresh period
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         refresh_cnt <= '0;
      end else if (refresh_cnt == CNT_W'(REFRESH_PERIOD - 1)) begin
         refresh_cnt <= '0;
      end else begin
         refresh_cnt <= refresh_cnt + 1'b1;
      end
   end

   assign mem_req_rdy = (refresh_cnt != CNT_W'(REFRESH_PERIOD - 1));
   assign take        = mem_req_vld & mem_req_rdy;

   always_ff @(posedge clk) begin
      if (take && mem_wr_en) begin
         mem[mem_addr] <= mem_wr_data;
      end
      if (take && mem_rd_en) begin
         mem_rd_data <= mem[mem_addr];
      end
   end

   // entry_vld travels with the ack, for the entry that was addressed
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid       <= '0;
         mem_ack_vld <= 1'b0;
         entry_vld   <= 1'b0;
      end else begin
         mem_ack_vld <= take;
         if (take) begin
            entry_vld <= valid[mem_addr];
         end
         if (take && mem_wr_en) begin
            valid[mem_addr] <= 1'b1;
         end
      end
   end

endmodule

// ==== hdl/snapshot_reg_mem.sv ====
module snapshot_reg_mem
   import xreg_pkg::*;
#(
   parameter int                     DATA_WIDTH  = 32,
   parameter int                     MEM_WIDTH   = 36,
   parameter int                     ENTRY_WIDTH = 4,
   parameter logic [HOST_ADDR_W-1:0] BASE        = 8'h80
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [HOST_ADDR_W-1:0] addr,
   input  logic                   wr_en,
   input  logic                   rd_en,
   input  logic [DATA_WIDTH-1:0]  wr_data,
   input  logic                   req_vld,
   output logic                   req_rdy,
   output logic                   ack_vld,
   output logic [DATA_WIDTH-1:0]  rd_data,
   input  logic                   write_protect,
   input  logic                   entry_vld,
   output logic [ENTRY_WIDTH-1:0] mem_addr,
   output logic                   mem_req_vld,
   output logic                   mem_rd_en,
   output logic                   mem_wr_en,
   output logic [MEM_WIDTH-1:0]   mem_wr_data,
   input  logic                   mem_req_rdy,
   input  logic                   mem_ack_vld,
   input  logic [MEM_WIDTH-1:0]   mem_rd_data
);

   localparam int PART_CNT   = (MEM_WIDTH + DATA_WIDTH - 1) / DATA_WIDTH;
   localparam int HI_W       = MEM_WIDTH - DATA_WIDTH;
   localparam int PART_LSB   = clog2_f(DATA_WIDTH / 8);
   localparam int PART_SEL_W = (PART_CNT > 1) ? clog2_f(PART_CNT) : 1;
   localparam int ENTRY_LSB  = PART_LSB + PART_SEL_W;
   localparam int PAD_W      = PART_CNT * DATA_WIDTH;

   snap_state_e            state_q;
   snap_state_e            state_d;
   logic [HOST_ADDR_W-1:0] offset;
   logic [PART_SEL_W-1:0]  part_idx;
   logic [PART_CNT-1:0]    part_dec;
   logic [ENTRY_WIDTH-1:0] entry_dec;
   logic                   in_idle;
   logic                   accept;
   logic                   mem_access;
   logic [PART_CNT-1:0]    part_sel_q;
   logic [ENTRY_WIDTH-1:0] entry_q;
   logic                   op_rd_q;
   logic                   op_wr_q;
   logic [MEM_WIDTH-1:0]   snapshot;
   logic [PAD_W-1:0]       snapshot_pad;
   logic [PART_CNT-1:0]    rd_sel;

   // byte offset into the window, then partition and entry fields
   assign offset    = addr - BASE;
   assign part_idx  = offset[PART_LSB +: PART_SEL_W];
   assign entry_dec = offset[ENTRY_LSB +: ENTRY_WIDTH];
   assign part_dec  = PART_CNT'(1) << part_idx;

   assign in_idle = (state_q == IDLE);
   assign accept  = in_idle & req_vld;
   assign req_rdy = in_idle;
   assign ack_vld = (state_q == OP_DATA);

   // only partition 0 goes to memory, a protected write never does
   assign mem_access = part_dec[0] & (rd_en | (wr_en & ~write_protect));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      case (state_q)
         IDLE: begin
            if (!req_vld) begin
               state_d = IDLE;
            end else if (!mem_access) begin
               state_d = OP_DATA;
            end else begin
               state_d = mem_req_rdy ? SNAPSHOT : WT_HW;
            end
         end
         WT_HW:    state_d = mem_req_rdy ? SNAPSHOT : WT_HW;
         SNAPSHOT: state_d = mem_ack_vld ? OP_DATA : SNAPSHOT;
         OP_DATA:  state_d = IDLE;
         default:  state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         part_sel_q <= '0;
         op_rd_q    <= 1'b0;
         op_wr_q    <= 1'b0;
      end else if (accept) begin
         part_sel_q <= part_dec;
         op_rd_q    <= rd_en;
         op_wr_q    <= wr_en;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         entry_q <= entry_dec;
      end
   end

   // whole entry from memory, or partition words from host writes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snapshot <= '0;
      end else if ((state_q == SNAPSHOT) && mem_ack_vld && op_rd_q) begin
         snapshot <= entry_vld ? mem_rd_data : '0;
      end else if (accept && wr_en) begin
         if (part_dec[0] && !write_protect) begin
            snapshot[DATA_WIDTH-1:0] <= wr_data;
         end
         if (part_dec[1]) begin
            snapshot[MEM_WIDTH-1:DATA_WIDTH] <= wr_data[HI_W-1:0];
         end
      end
   end

   // first request cycle comes straight from the frontend, later ones from the latches
   assign mem_req_vld = (accept & mem_access) | (state_q == WT_HW);
   assign mem_addr    = in_idle ? entry_dec : entry_q;
   assign mem_rd_en   = mem_req_vld & (in_idle ? rd_en : op_rd_q);
   assign mem_wr_en   = mem_req_vld & (in_idle ? wr_en : op_wr_q);
   assign mem_wr_data = in_idle ? {snapshot[MEM_WIDTH-1:DATA_WIDTH], wr_data} : snapshot;

   assign snapshot_pad = PAD_W'(snapshot);
   assign rd_sel       = part_sel_q & {PART_CNT{op_rd_q}};

   onehot_mux #(
      .WIDTH (DATA_WIDTH),
      .CNT   (PART_CNT)
   ) rd_mux_inst (
      .din  (snapshot_pad),
      .sel  (rd_sel),
      .dout (rd_data)
   );

endmodule

// ==== hdl/reg_bus_frontend.sv ====
module reg_bus_frontend
   import xreg_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   host_wr,
   input  logic                   host_rd,
   input  logic [HOST_ADDR_W-1:0] host_addr,
   input  logic [DATA_W-1:0]      host_wdata,
   output logic                   req_vld,
   output logic [HOST_ADDR_W-1:0] addr,
   output logic                   wr_en,
   output logic                   rd_en,
   output logic [DATA_W-1:0]      wr_data,
   output logic                   ctrl_wr,
   output logic                   ctrl_rd,
   output logic [DATA_W-1:0]      wdata,
   input  logic                   req_rdy
);

   logic strobe;
   logic win_hit;
   logic ctrl_side;
   logic ctrl_hit;

   assign strobe    = host_wr | host_rd;
   assign win_hit   = strobe & host_addr[HOST_ADDR_W-1];
   assign ctrl_side = strobe & ~host_addr[HOST_ADDR_W-1];
   assign ctrl_hit  = (host_addr == CTRL_ADDR);

   // window access stays pending until the bridge takes it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_vld <= 1'b0;
         wr_en   <= 1'b0;
         rd_en   <= 1'b0;
      end else if (win_hit) begin
         req_vld <= 1'b1;
         wr_en   <= host_wr;
         rd_en   <= host_rd;
      end else if (req_rdy) begin
         req_vld <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (win_hit) begin
         addr    <= host_addr;
         wr_data <= host_wdata;
      end
   end

   // everything below the window is answered by resp_path
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_wr <= 1'b0;
         ctrl_rd <= 1'b0;
      end else begin
         ctrl_wr <= ctrl_side & host_wr & ctrl_hit;
         ctrl_rd <= ctrl_side & ~(host_wr & ctrl_hit);
      end
   end

   // on reads wdata is a mask, all ones only for a control register hit
   always_ff @(posedge clk) begin
      if (ctrl_side) begin
         wdata <= (host_wr & ctrl_hit) ? host_wdata : {DATA_W{host_rd & ctrl_hit}};
      end
   end

endmodule

// ==== hdl/onehot_mux.sv ====
module onehot_mux
   import xreg_pkg::*;
#(
   parameter int WIDTH = 32,
   parameter int CNT   = 2
) (
   input  logic [CNT*WIDTH-1:0] din,
   input  logic [CNT-1:0]       sel,
   output logic [WIDTH-1:0]     dout
);

   localparam int LEVELS = clog2_f(CNT);
   localparam int LEAVES = 1 << LEVELS;

   logic [LEAVES*WIDTH-1:0] din_pad;
   logic [LEAVES-1:0]       sel_pad;
   logic [WIDTH-1:0]        node [2*LEAVES-1];

   assign din_pad = (LEAVES*WIDTH)'(din);
   assign sel_pad = LEAVES'(sel);

   // leaves hold the masked words, each inner node ORs its two children
   always_comb begin
      for (int k = 0; k < LEAVES; k++) begin
         node[LEAVES-1+k] = sel_pad[k] ? din_pad[k*WIDTH +: WIDTH] : '0;
      end
      for (int k = LEAVES - 2; k >= 0; k--) begin
         node[k] = node[2*k+1] | node[2*k+2];
      end
   end

   assign dout = node[0];

endmodule

// ==== hdl/xreg_pkg.sv ====
package xreg_pkg;

   `include "xreg_funcs.svh"

   // host side
   localparam int DATA_W      = 32;
   localparam int HOST_ADDR_W = 8;

   // entry memory
   localparam int MEM_W   = 36;
   localparam int ENTRY_W = 4;

   // address map
   localparam logic [HOST_ADDR_W-1:0] WIN_BASE  = 8'h80;
   localparam logic [HOST_ADDR_W-1:0] CTRL_ADDR = 8'h00;

   // bridge FSM, one-hot
   typedef enum logic [3:0] {
      IDLE     = 4'b0001,
      WT_HW    = 4'b0010,
      SNAPSHOT = 4'b0100,
      OP_DATA  = 4'b1000
   } snap_state_e;

endpackage

// ==== include/xreg_funcs.svh ====
`ifndef XREG_FUNCS_SVH
`define XREG_FUNCS_SVH

// ceiling log2, returns 0 for values of 0 and 1
function automatic int clog2_f(input int value);
   int result;
   int rest;
   result = 0;
   rest   = value - 1;
   while (rest > 0) begin
      result = result + 1;
      rest   = rest >> 1;
   end
   return result;
endfunction

`endif
